//--- hw/lsu_pkg.sv
// Shared types for a bare-mode RV32 LSU; no MMU, AMO, FP or 64-bit access support
`default_nettype none

package lsu_pkg;

  // ------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------
  localparam int unsigned XLEN          = 32;
  localparam int unsigned TRANS_ID_BITS = 3;
  localparam int unsigned BE_BITS       = 4;

  // Exception causes as in the privileged spec
  localparam logic [3:0] CAUSE_LD_MISALIGNED = 4'd4;
  localparam logic [3:0] CAUSE_ST_MISALIGNED = 4'd6;

  typedef enum logic [3:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } lsu_op_e;

  // ------------------------------------------------------------
  // Structs
  // ------------------------------------------------------------
  typedef struct packed {
    logic            valid;
    logic [3:0]      cause;
    logic [XLEN-1:0] tval;
  } exception_t;

  // Issue word, operand_b carries the store data
  typedef struct packed {
    lsu_op_e                  op;
    logic [XLEN-1:0]          operand_a;
    logic [XLEN-1:0]          operand_b;
    logic [11:0]              imm;
    logic [TRANS_ID_BITS-1:0] trans_id;
  } fu_data_t;

  typedef struct packed {
    logic                     is_store;
    lsu_op_e                  op;
    logic [XLEN-1:0]          vaddr;
    logic [XLEN-1:0]          wdata;
    logic [BE_BITS-1:0]       be;
    logic [TRANS_ID_BITS-1:0] trans_id;
    exception_t               ex;
  } lsu_ctrl_t;

  // Word addressed, so addr drops the two byte offset bits
  typedef struct packed {
    logic               req;
    logic               we;
    logic [XLEN-3:0]    addr;
    logic [BE_BITS-1:0] be;
    logic [XLEN-1:0]    wdata;
  } mem_req_t;

  typedef struct packed {
    logic            gnt;
    logic            rvalid;
    logic [XLEN-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic                     valid;
    logic [TRANS_ID_BITS-1:0] trans_id;
    logic [XLEN-1:0]          result;
    exception_t               ex;
  } lsu_result_t;

endpackage

`default_nettype wire

//--- hw/lsu_agu.sv
// Purely combinational; physical address equals virtual address, misaligned accesses trap
`timescale 1ns/1ps
`default_nettype none

module lsu_agu (
  input  lsu_pkg::fu_data_t  fu_data_i,
  output lsu_pkg::lsu_ctrl_t ctrl_o
);

  logic [lsu_pkg::XLEN-1:0]    vaddr;
  logic [lsu_pkg::BE_BITS-1:0] be;
  logic                        is_store;
  logic                        misaligned;

  // Base plus sign-extended 12-bit offset
  assign vaddr = fu_data_i.operand_a + {{(lsu_pkg::XLEN - 12){fu_data_i.imm[11]}}, fu_data_i.imm};

  // ------------------------------------------------------------
  // Size decode, byte enables and alignment check
  // ------------------------------------------------------------
  always_comb begin
    is_store   = 1'b0;
    misaligned = 1'b0;
    be         = 4'b1111;
    case (fu_data_i.op)
      lsu_pkg::LB, lsu_pkg::LBU: begin
        be = 4'b0001 << vaddr[1:0];
      end
      lsu_pkg::SB: begin
        is_store = 1'b1;
        be       = 4'b0001 << vaddr[1:0];
      end
      lsu_pkg::LH, lsu_pkg::LHU: begin
        be         = 4'b0011 << vaddr[1:0];
        misaligned = vaddr[0];
      end
      lsu_pkg::SH: begin
        is_store   = 1'b1;
        be         = 4'b0011 << vaddr[1:0];
        misaligned = vaddr[0];
      end
      lsu_pkg::SW: begin
        is_store   = 1'b1;
        misaligned = |vaddr[1:0];
      end
      // LW and anything unknown read the full word
      default: begin
        misaligned = |vaddr[1:0];
      end
    endcase
  end

  // No exception leaves the whole ex field at zero
  always_comb begin
    ctrl_o.is_store = is_store;
    ctrl_o.op       = fu_data_i.op;
    ctrl_o.vaddr    = vaddr;
    ctrl_o.wdata    = fu_data_i.operand_b;
    ctrl_o.be       = be;
    ctrl_o.trans_id = fu_data_i.trans_id;
    ctrl_o.ex.valid = misaligned;
    ctrl_o.ex.cause = misaligned ? (is_store ? lsu_pkg::CAUSE_ST_MISALIGNED :
                                              lsu_pkg::CAUSE_LD_MISALIGNED) : '0;
    ctrl_o.ex.tval  = misaligned ? vaddr : '0;
  end

endmodule

`default_nettype wire

//--- hw/lsu_issue_queue.sv
// Two entries only; a push during flush is dropped, a pop on an empty queue is ignored
`timescale 1ns/1ps
`default_nettype none

module lsu_issue_queue (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  input  logic               push_i,
  input  lsu_pkg::lsu_ctrl_t data_i,
  output logic               ready_o,
  output logic               head_valid_o,
  output lsu_pkg::lsu_ctrl_t head_o,
  input  logic               pop_i
);

  lsu_pkg::lsu_ctrl_t mem_q [2];
  logic               rd_ptr_q;
  logic               wr_ptr_q;
  logic [1:0]         count_q;
  logic               push;
  logic               pop;

  assign ready_o      = (count_q != 2'd2);
  assign head_valid_o = (count_q != 2'd0);
  assign head_o       = mem_q[rd_ptr_q];

  assign push = push_i && ready_o && !flush_i;
  assign pop  = pop_i && head_valid_o && !flush_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else if (flush_i) begin
      rd_ptr_q <= 1'b0;
      wr_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // The units only take an operation that is really at the head
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> head_valid_o)
    else $error("issue queue popped while empty");

endmodule

`default_nettype wire

//--- hw/lsu_load_unit.sv
// One read in flight; a flushed read still completes on the bus but reports no result
`timescale 1ns/1ps
`default_nettype none

module lsu_load_unit (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 head_valid_i,
  input  lsu_pkg::lsu_ctrl_t   head_i,
  output logic                 pop_o,
  input  logic                 store_conflict_i,
  output lsu_pkg::mem_req_t    req_o,
  input  lsu_pkg::mem_rsp_t    rsp_i,
  output lsu_pkg::lsu_result_t result_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT
  } state_e;

  state_e                                state_q;
  state_e                                state_d;
  logic                                  capture;
  logic                                  kill_q;
  lsu_pkg::lsu_op_e                      op_q;
  logic [1:0]                            off_q;
  logic [lsu_pkg::XLEN-3:0]              addr_q;
  logic [lsu_pkg::TRANS_ID_BITS-1:0]     trans_id_q;
  logic [lsu_pkg::XLEN-1:0]              shifted;
  logic [lsu_pkg::XLEN-1:0]              ext_data;
  lsu_pkg::lsu_result_t                  result_d;

  // ------------------------------------------------------------
  // Sequencing
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    pop_o   = 1'b0;
    capture = 1'b0;
    case (state_q)
      S_IDLE: begin
        if (head_valid_i && !head_i.is_store && !flush_i) begin
          if (head_i.ex.valid) begin
            pop_o = 1'b1;
          end else if (!store_conflict_i) begin
            // Wait here while a queued store still owns this word
            pop_o   = 1'b1;
            capture = 1'b1;
            state_d = S_REQ;
          end
        end
      end
      S_REQ: begin
        if (rsp_i.gnt) begin
          state_d = S_WAIT;
        end
      end
      S_WAIT: begin
        if (rsp_i.rvalid) begin
          state_d = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  // While idle the address carries the head's word for the store queue compare
  assign req_o.req   = (state_q == S_REQ);
  assign req_o.we    = 1'b0;
  assign req_o.addr  = (state_q == S_IDLE) ? head_i.vaddr[lsu_pkg::XLEN-1:2] : addr_q;
  assign req_o.be    = '1;
  assign req_o.wdata = '0;

  // ------------------------------------------------------------
  // Byte lane select and extension
  // ------------------------------------------------------------
  assign shifted = rsp_i.rdata >> {off_q, 3'b000};

  always_comb begin
    case (op_q)
      lsu_pkg::LB:  ext_data = {{24{shifted[7]}}, shifted[7:0]};
      lsu_pkg::LBU: ext_data = {24'b0, shifted[7:0]};
      lsu_pkg::LH:  ext_data = {{16{shifted[15]}}, shifted[15:0]};
      lsu_pkg::LHU: ext_data = {16'b0, shifted[15:0]};
      default:      ext_data = rsp_i.rdata;
    endcase
  end

  always_comb begin
    result_d = '0;
    if (pop_o && head_i.ex.valid) begin
      result_d.valid    = 1'b1;
      result_d.trans_id = head_i.trans_id;
      result_d.ex       = head_i.ex;
    end else if (state_q == S_WAIT && rsp_i.rvalid) begin
      result_d.valid    = !kill_q && !flush_i;
      result_d.trans_id = trans_id_q;
      result_d.result   = ext_data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= S_IDLE;
      kill_q   <= 1'b0;
      result_o <= '0;
    end else begin
      state_q  <= state_d;
      result_o <= result_d;
      if (capture) begin
        kill_q <= 1'b0;
      end else if (flush_i && state_q != S_IDLE) begin
        kill_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      op_q       <= head_i.op;
      off_q      <= head_i.vaddr[1:0];
      addr_q     <= head_i.vaddr[lsu_pkg::XLEN-1:2];
      trans_id_q <= head_i.trans_id;
    end
  end

  // Memory must not answer a read that was never issued
  assert property (@(posedge clk_i) disable iff (!rst_ni) rsp_i.rvalid |-> state_q == S_WAIT)
    else $error("load port rvalid without an outstanding read");

endmodule

`default_nettype wire

//--- hw/lsu_store_queue.sv
// Commits must follow issue order; flush keeps committed stores, which still drain to memory
`timescale 1ns/1ps
`default_nettype none

module lsu_store_queue #(
  parameter int unsigned STORE_QUEUE_DEPTH = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  logic                     head_valid_i,
  input  lsu_pkg::lsu_ctrl_t       head_i,
  output logic                     pop_o,
  input  logic                     commit_i,
  output logic                     commit_ready_o,
  output logic                     no_st_pending_o,
  input  logic [lsu_pkg::XLEN-3:0] load_word_i,
  output logic                     store_conflict_o,
  output lsu_pkg::mem_req_t        req_o,
  input  lsu_pkg::mem_rsp_t        rsp_i,
  output lsu_pkg::lsu_result_t     result_o
);

  localparam int unsigned PTR_W = (STORE_QUEUE_DEPTH > 1) ? $clog2(STORE_QUEUE_DEPTH) : 1;

  typedef struct packed {
    logic [lsu_pkg::XLEN-3:0]    addr;
    logic [lsu_pkg::BE_BITS-1:0] be;
    logic [lsu_pkg::XLEN-1:0]    data;
  } sq_entry_t;

  sq_entry_t                      entry_q [STORE_QUEUE_DEPTH];
  logic [STORE_QUEUE_DEPTH-1:0]   valid_q;
  logic [STORE_QUEUE_DEPTH-1:0]   committed_q;
  logic [PTR_W-1:0]               wr_ptr_q;
  logic [PTR_W-1:0]               commit_ptr_q;
  logic [PTR_W-1:0]               rd_ptr_q;
  logic                           push;
  logic                           write_done;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(STORE_QUEUE_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // ------------------------------------------------------------
  // Accept from the issue queue
  // ------------------------------------------------------------
  // Faulting stores retire at once and never take an entry
  assign pop_o = head_valid_i && head_i.is_store && !flush_i &&
                 (head_i.ex.valid || !valid_q[wr_ptr_q]);
  assign push  = pop_o && !head_i.ex.valid;

  // Oldest uncommitted entry sits at the commit pointer
  assign commit_ready_o  = valid_q[commit_ptr_q] && !committed_q[commit_ptr_q];
  assign no_st_pending_o = ~|valid_q;

  always_comb begin
    store_conflict_o = 1'b0;
    for (int i = 0; i < STORE_QUEUE_DEPTH; i++) begin
      if (valid_q[i] && entry_q[i].addr == load_word_i) begin
        store_conflict_o = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Memory write of the oldest committed entry
  // ------------------------------------------------------------
  assign req_o.req   = valid_q[rd_ptr_q] && committed_q[rd_ptr_q];
  assign req_o.we    = 1'b1;
  assign req_o.addr  = entry_q[rd_ptr_q].addr;
  assign req_o.be    = entry_q[rd_ptr_q].be;
  assign req_o.wdata = entry_q[rd_ptr_q].data;
  assign write_done  = req_o.req && rsp_i.gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q      <= '0;
      committed_q  <= '0;
      wr_ptr_q     <= '0;
      commit_ptr_q <= '0;
      rd_ptr_q     <= '0;
      result_o     <= '0;
    end else begin
      result_o.valid    <= pop_o;
      result_o.trans_id <= head_i.trans_id;
      result_o.result   <= '0;
      result_o.ex       <= head_i.ex;
      if (push) begin
        valid_q[wr_ptr_q] <= 1'b1;
        wr_ptr_q          <= ptr_inc(wr_ptr_q);
      end
      if (commit_i) begin
        committed_q[commit_ptr_q] <= 1'b1;
        commit_ptr_q              <= ptr_inc(commit_ptr_q);
      end
      if (write_done) begin
        valid_q[rd_ptr_q]     <= 1'b0;
        committed_q[rd_ptr_q] <= 1'b0;
        rd_ptr_q              <= ptr_inc(rd_ptr_q);
      end
      // Drop speculative entries, a commit in the same cycle still counts
      if (flush_i) begin
        for (int i = 0; i < STORE_QUEUE_DEPTH; i++) begin
          if (!committed_q[i] && !(commit_i && commit_ptr_q == PTR_W'(i))) begin
            valid_q[i] <= 1'b0;
          end
        end
        wr_ptr_q <= commit_i ? ptr_inc(commit_ptr_q) : commit_ptr_q;
      end
    end
  end

  // Store data moves into its byte lanes on the way in
  always_ff @(posedge clk_i) begin
    if (push) begin
      entry_q[wr_ptr_q].addr <= head_i.vaddr[lsu_pkg::XLEN-1:2];
      entry_q[wr_ptr_q].be   <= head_i.be;
      entry_q[wr_ptr_q].data <= head_i.wdata << {head_i.vaddr[1:0], 3'b000};
    end
  end

  // The core only retires stores that the queue holds
  assert property (@(posedge clk_i) disable iff (!rst_ni) commit_i |-> commit_ready_o)
    else $error("commit without an uncommitted store");

endmodule

`default_nettype wire

//--- hw/lsu_result_pipe.sv
// DEPTH of 0 gives a direct path; every stage is cleared by reset
`timescale 1ns/1ps
`default_nettype none

module lsu_result_pipe #(
  parameter int unsigned DEPTH = 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  lsu_pkg::lsu_result_t d_i,
  output lsu_pkg::lsu_result_t d_o
);

  if (DEPTH == 0) begin : gen_bypass
    assign d_o = d_i;
  end else begin : gen_regs
    lsu_pkg::lsu_result_t pipe_q [DEPTH];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        for (int i = 0; i < DEPTH; i++) begin
          pipe_q[i] <= '0;
        end
      end else begin
        pipe_q[0] <= d_i;
        for (int i = 1; i < DEPTH; i++) begin
          pipe_q[i] <= pipe_q[i-1];
        end
      end
    end

    assign d_o = pipe_q[DEPTH-1];
  end

endmodule

`default_nettype wire

//--- hw/lsu_top.sv
// Bare-mode RV32 LSU; separate load and store ports, stores wait for commit_i before writing
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
  parameter int unsigned STORE_QUEUE_DEPTH  = 4,
  parameter int unsigned NR_LOAD_PIPE_REGS  = 1,
  parameter int unsigned NR_STORE_PIPE_REGS = 1
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  // Issue side
  input  lsu_pkg::fu_data_t    fu_data_i,
  input  logic                 lsu_valid_i,
  output logic                 lsu_ready_o,
  // Commit side
  input  logic                 commit_i,
  output logic                 commit_ready_o,
  output logic                 no_st_pending_o,
  // Results
  output lsu_pkg::lsu_result_t load_result_o,
  output lsu_pkg::lsu_result_t store_result_o,
  // Memory ports
  output lsu_pkg::mem_req_t    ld_mem_req_o,
  input  lsu_pkg::mem_rsp_t    ld_mem_rsp_i,
  output lsu_pkg::mem_req_t    st_mem_req_o,
  input  lsu_pkg::mem_rsp_t    st_mem_rsp_i
);

  lsu_pkg::lsu_ctrl_t   agu_ctrl;
  lsu_pkg::lsu_ctrl_t   head;
  logic                 head_valid;
  logic                 ld_pop;
  logic                 st_pop;
  logic                 store_conflict;
  lsu_pkg::lsu_result_t ld_result;
  lsu_pkg::lsu_result_t st_result;

  lsu_agu i_agu (
    .fu_data_i (fu_data_i),
    .ctrl_o    (agu_ctrl)
  );

  lsu_issue_queue i_issue_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .push_i       (lsu_valid_i),
    .data_i       (agu_ctrl),
    .ready_o      (lsu_ready_o),
    .head_valid_o (head_valid),
    .head_o       (head),
    .pop_i        (ld_pop | st_pop)
  );

  lsu_load_unit i_load_unit (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .head_valid_i     (head_valid),
    .head_i           (head),
    .pop_o            (ld_pop),
    .store_conflict_i (store_conflict),
    .req_o            (ld_mem_req_o),
    .rsp_i            (ld_mem_rsp_i),
    .result_o         (ld_result)
  );

  // Load port address doubles as the word compared against queued stores
  lsu_store_queue #(
    .STORE_QUEUE_DEPTH (STORE_QUEUE_DEPTH)
  ) i_store_queue (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .head_valid_i     (head_valid),
    .head_i           (head),
    .pop_o            (st_pop),
    .commit_i         (commit_i),
    .commit_ready_o   (commit_ready_o),
    .no_st_pending_o  (no_st_pending_o),
    .load_word_i      (ld_mem_req_o.addr),
    .store_conflict_o (store_conflict),
    .req_o            (st_mem_req_o),
    .rsp_i            (st_mem_rsp_i),
    .result_o         (st_result)
  );

  lsu_result_pipe #(
    .DEPTH (NR_LOAD_PIPE_REGS)
  ) i_load_pipe (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (ld_result),
    .d_o    (load_result_o)
  );

  lsu_result_pipe #(
    .DEPTH (NR_STORE_PIPE_REGS)
  ) i_store_pipe (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .d_i    (st_result),
    .d_o    (store_result_o)
  );

endmodule

`default_nettype wire

//--- tb/lsu_tb_mem.sv
// Behavioral memory of 256 words; word address bits above 7 are ignored, grants wait 0 to 3 cycles
`timescale 1ns/1ps
`default_nettype none

module lsu_tb_mem (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  lsu_pkg::mem_req_t ld_req_i,
  output lsu_pkg::mem_rsp_t ld_rsp_o,
  input  lsu_pkg::mem_req_t st_req_i,
  output lsu_pkg::mem_rsp_t st_rsp_o
);

  logic [31:0] mem [256];
  logic [31:0] lfsr_q;
  logic [7:0]  ld_addr_q;
  logic [1:0]  ld_wait_q;
  logic [1:0]  st_wait_q;

  // Galois LFSR, one step per delay bit
  function automatic logic [1:0] next_delay();
    logic [1:0] v;
    v = '0;
    for (int i = 0; i < 2; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
      v = {v[0], lfsr_q[0]};
    end
    return v;
  endfunction

  initial begin
    lfsr_q   = 32'h6b7b;
    ld_rsp_o = '0;
    st_rsp_o = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'h9E3779B9 * 32'(i + 1);
    end
  end

  // ------------------------------------------------------------
  // Responses change on the falling edge only
  // ------------------------------------------------------------
  always @(negedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ld_rsp_o  <= '0;
      st_rsp_o  <= '0;
      ld_wait_q <= '0;
      st_wait_q <= '0;
    end else begin
      ld_rsp_o.rvalid <= 1'b0;
      if (ld_rsp_o.gnt) begin
        // Read data one cycle after the grant
        ld_rsp_o.gnt    <= 1'b0;
        ld_rsp_o.rvalid <= 1'b1;
        ld_rsp_o.rdata  <= mem[ld_addr_q];
      end else if (ld_req_i.req) begin
        if (ld_wait_q == 2'd0) begin
          ld_rsp_o.gnt <= 1'b1;
          ld_addr_q    <= ld_req_i.addr[7:0];
          ld_wait_q    <= next_delay();
        end else begin
          ld_wait_q <= ld_wait_q - 2'd1;
        end
      end
      if (st_rsp_o.gnt) begin
        st_rsp_o.gnt <= 1'b0;
      end else if (st_req_i.req) begin
        if (st_wait_q == 2'd0) begin
          st_rsp_o.gnt <= 1'b1;
          st_wait_q    <= next_delay();
          for (int b = 0; b < 4; b++) begin
            if (st_req_i.be[b]) begin
              mem[st_req_i.addr[7:0]][8*b +: 8] <= st_req_i.wdata[8*b +: 8];
            end
          end
        end else begin
          st_wait_q <= st_wait_q - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/lsu_tb.sv
// Stimulus keeps addresses below 0x400; loads older than a store are drained before it commits
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

  logic                 clk_i, rst_ni, flush_i, lsu_valid_i, lsu_ready_o;
  logic                 commit_i, commit_ready_o, no_st_pending_o;
  lsu_pkg::fu_data_t    fu_data_i;
  lsu_pkg::lsu_result_t load_result_o, store_result_o, exp_ld, exp_st;
  lsu_pkg::mem_req_t    ld_req, st_req;
  lsu_pkg::mem_rsp_t    ld_rsp, st_rsp;

  lsu_pkg::lsu_result_t exp_ld_mem [1024];
  lsu_pkg::lsu_result_t exp_st_mem [1024];
  int                   ld_seq [1024];
  logic [7:0]           pend_word [1024];
  logic [3:0]           pend_be [1024];
  logic [31:0]          pend_data [1024];
  int                   pend_seq [1024];
  logic [31:0]          image [256];
  int ld_wr, ld_rd, st_wr, st_rd, pend_cnt, commit_idx, seq, commit_allow;
  int ld_grants, st_grants, ld_reads;
  int mism_cnt, fail_cnt;
  logic [31:0] lfsr_q;
  logic [2:0]  next_tid;
  logic        saw_full;
  logic        exp_ld_valid, exp_st_valid;

  lsu_top UUT (
    .clk_i (clk_i), .rst_ni (rst_ni), .flush_i (flush_i),
    .fu_data_i (fu_data_i), .lsu_valid_i (lsu_valid_i), .lsu_ready_o (lsu_ready_o),
    .commit_i (commit_i), .commit_ready_o (commit_ready_o),
    .no_st_pending_o (no_st_pending_o),
    .load_result_o (load_result_o), .store_result_o (store_result_o),
    .ld_mem_req_o (ld_req), .ld_mem_rsp_i (ld_rsp),
    .st_mem_req_o (st_req), .st_mem_rsp_i (st_rsp)
  );

  lsu_tb_mem i_mem (
    .clk_i (clk_i), .rst_ni (rst_ni), .ld_req_i (ld_req), .ld_rsp_o (ld_rsp),
    .st_req_i (st_req), .st_rsp_o (st_rsp)
  );

  assign exp_ld       = exp_ld_mem[ld_rd];
  assign exp_st       = exp_st_mem[st_rd];
  assign exp_ld_valid = (ld_rd != ld_wr);
  assign exp_st_valid = (st_rd != st_wr);

  // ------------------------------------------------------------
  // Result checks, sampled mid-cycle while results are stable
  // ------------------------------------------------------------
  assert property (@(negedge clk_i) disable iff (!rst_ni) load_result_o.valid |-> exp_ld_valid)
    else begin
      fail_cnt++;
      $display("load result arrived with no load outstanding");
    end
  assert property (@(negedge clk_i) disable iff (!rst_ni)
                   (load_result_o.valid && exp_ld_valid) |-> load_result_o == exp_ld)
    else begin
      mism_cnt++;
      $display("mismatch load_result_o: expected %h, got %h",
               $sampled(exp_ld), $sampled(load_result_o));
    end
  assert property (@(negedge clk_i) disable iff (!rst_ni) store_result_o.valid |-> exp_st_valid)
    else begin
      fail_cnt++;
      $display("store result arrived with no store outstanding");
    end
  assert property (@(negedge clk_i) disable iff (!rst_ni)
                   (store_result_o.valid && exp_st_valid) |-> store_result_o == exp_st)
    else begin
      mism_cnt++;
      $display("mismatch store_result_o: expected %h, got %h",
               $sampled(exp_st), $sampled(store_result_o));
    end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] w, input logic [3:0] be,
                                              input logic [31:0] d);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) w[8*b +: 8] = d[8*b +: 8];
    end
    return w;
  endfunction

  // Word as a load will see it, older queued stores included
  function automatic logic [31:0] load_value(input lsu_pkg::lsu_op_e op, input logic [31:0] a);
    logic [31:0] w;
    w = image[a[9:2]];
    for (int i = commit_idx; i < pend_cnt; i++) begin
      if (pend_word[i] == a[9:2]) w = merge_bytes(w, pend_be[i], pend_data[i]);
    end
    w = w >> {a[1:0], 3'b000};
    case (op)
      lsu_pkg::LB:  return {{24{w[7]}}, w[7:0]};
      lsu_pkg::LBU: return {24'h0, w[7:0]};
      lsu_pkg::LH:  return {{16{w[15]}}, w[15:0]};
      lsu_pkg::LHU: return {16'h0, w[15:0]};
      default:      return w;
    endcase
  endfunction

  task automatic record_issue();
    logic [31:0] a;
    logic        st, mis;
    lsu_pkg::lsu_op_e op;
    lsu_pkg::lsu_result_t r;
    op  = fu_data_i.op;
    a   = fu_data_i.operand_a + {{20{fu_data_i.imm[11]}}, fu_data_i.imm};
    st  = op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};
    mis = (op inside {lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH} && a[0]) ||
          (op inside {lsu_pkg::LW, lsu_pkg::SW} && a[1:0] != 2'b00);
    r          = '0;
    r.valid    = 1'b1;
    r.trans_id = fu_data_i.trans_id;
    if (mis) begin
      r.ex.valid = 1'b1;
      r.ex.cause = st ? 4'd6 : 4'd4;
      r.ex.tval  = a;
    end else if (!st) begin
      r.result = load_value(op, a);
      ld_reads++;
    end else begin
      pend_word[pend_cnt] = a[9:2];
      pend_be[pend_cnt]   = (op == lsu_pkg::SW) ? 4'hF :
                            ((op == lsu_pkg::SH) ? 4'b0011 : 4'b0001) << a[1:0];
      pend_data[pend_cnt] = fu_data_i.operand_b << {a[1:0], 3'b000};
      pend_seq[pend_cnt]  = seq;
      pend_cnt++;
    end
    if (st) begin
      exp_st_mem[st_wr] = r;
      st_wr++;
    end else begin
      exp_ld_mem[ld_wr] = r;
      ld_seq[ld_wr]     = seq;
      ld_wr++;
    end
    seq++;
  endtask

  // Issue, commit, flush and port grants as the DUT sees them
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (lsu_valid_i) record_issue();
      if (commit_i) begin
        image[pend_word[commit_idx]] = merge_bytes(image[pend_word[commit_idx]],
                                                   pend_be[commit_idx], pend_data[commit_idx]);
        commit_idx++;
      end
      if (flush_i) pend_cnt = commit_idx;
      if (ld_req.req && ld_rsp.gnt) ld_grants++;
      if (st_req.req && st_rsp.gnt) st_grants++;
    end
  end

  always @(negedge clk_i) begin
    if (rst_ni && load_result_o.valid && exp_ld_valid) ld_rd <= ld_rd + 1;
    if (rst_ni && store_result_o.valid && exp_st_valid) st_rd <= st_rd + 1;
  end

  // A store commits only once every older load has its data
  always @(negedge clk_i) begin
    if (rst_ni && !flush_i && commit_allow > 0 && commit_ready_o && commit_idx < pend_cnt &&
        (!exp_ld_valid || ld_seq[ld_rd] > pend_seq[commit_idx])) begin
      commit_i = 1'b1;
      commit_allow--;
    end else begin
      commit_i = 1'b0;
    end
  end

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  task automatic report_timeout(input string what);
    fail_cnt++;
    $display("timeout: %s", what);
  endtask

  task automatic check_reset_value(input string name, input logic got, input logic exp);
    assert (got == exp) else begin
      mism_cnt++;
      $display("mismatch %s after reset: expected %h, got %h", name, exp, got);
    end
  endtask

  task automatic issue(input lsu_pkg::lsu_op_e op, input logic [31:0] base,
                       input logic [11:0] imm, input logic [31:0] data);
    int t;
    t = 0;
    while (!lsu_ready_o && t < 200) begin
      saw_full = 1'b1;
      @(negedge clk_i);
      t++;
    end
    if (!lsu_ready_o) begin
      report_timeout("issue queue never became ready");
    end else begin
      fu_data_i.op        = op;
      fu_data_i.operand_a = base;
      fu_data_i.operand_b = data;
      fu_data_i.imm       = imm;
      fu_data_i.trans_id  = next_tid;
      next_tid            = next_tid + 3'd1;
      lsu_valid_i         = 1'b1;
      @(negedge clk_i);
      lsu_valid_i = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (!(ld_rd == ld_wr && st_rd == st_wr && commit_idx == pend_cnt && no_st_pending_o) &&
           t < 3000) begin
      @(negedge clk_i);
      t++;
    end
    if (t == 3000) report_timeout("results or store writes did not drain");
  endtask

  initial begin
    logic [31:0] r, base;
    logic [11:0] imm;
    int t;
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    lsu_valid_i  = 1'b0;
    commit_i     = 1'b0;
    fu_data_i    = '0;
    lfsr_q       = 32'h6b7b;
    next_tid     = '0;
    saw_full     = 1'b0;
    ld_wr        = 0;
    ld_rd        = 0;
    st_wr        = 0;
    st_rd        = 0;
    pend_cnt     = 0;
    commit_idx   = 0;
    seq          = 0;
    ld_grants    = 0;
    st_grants    = 0;
    ld_reads     = 0;
    mism_cnt     = 0;
    fail_cnt     = 0;
    commit_allow = 1 << 30;
    for (int i = 0; i < 256; i++) image[i] = 32'h9E3779B9 * 32'(i + 1);
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    // Idle state right after reset
    check_reset_value("lsu_ready_o", lsu_ready_o, 1'b1);
    check_reset_value("load_result_o.valid", load_result_o.valid, 1'b0);
    check_reset_value("store_result_o.valid", store_result_o.valid, 1'b0);
    check_reset_value("ld_mem_req_o.req", ld_req.req, 1'b0);
    check_reset_value("st_mem_req_o.req", st_req.req, 1'b0);
    check_reset_value("commit_ready_o", commit_ready_o, 1'b0);
    check_reset_value("no_st_pending_o", no_st_pending_o, 1'b1);
    // Aligned loads of each size, then misaligned accesses
    issue(lsu_pkg::LB, 32'h100, 12'h003, '0);
    issue(lsu_pkg::LBU, 32'h100, 12'h001, '0);
    issue(lsu_pkg::LH, 32'h108, 12'hFFA, '0);
    issue(lsu_pkg::LHU, 32'h100, 12'h000, '0);
    issue(lsu_pkg::LW, 32'h100, 12'h004, '0);
    issue(lsu_pkg::LH, 32'h100, 12'h001, '0);
    issue(lsu_pkg::LW, 32'h100, 12'h002, '0);
    issue(lsu_pkg::SH, 32'h100, 12'h003, 32'h1234);
    issue(lsu_pkg::SW, 32'h100, 12'h006, 32'h5678);
    wait_drain();
    // Load behind an uncommitted store to the same word
    commit_allow = 0;
    issue(lsu_pkg::SB, 32'h200, 12'h001, 32'hAB);
    issue(lsu_pkg::LW, 32'h200, 12'h000, '0);
    t = 0;
    while (exp_st_valid && t < 200) begin
      @(negedge clk_i);
      t++;
    end
    if (t == 200) report_timeout("store result never arrived");
    repeat (8) @(negedge clk_i);
    assert (exp_ld_valid) else begin
      fail_cnt++;
      $display("load returned before the older store to its word was committed");
    end
    commit_allow = 1 << 30;
    wait_drain();
    // Random traffic
    saw_full = 1'b0;
    for (int n = 0; n < 200; n++) begin
      r    = rand_bits(4);
      base = 32'h100 + rand_bits(6);
      imm  = {{8{r[3]}}, r[3:0]};
      if (rand_bits(2) != 0) begin
        base[1:0] = 2'b00;
        imm[1:0]  = 2'b00;
      end
      r = rand_bits(3);
      issue(lsu_pkg::lsu_op_e'(r[3:0]), base, imm, rand_bits(32));
    end
    wait_drain();
    assert (saw_full) else begin
      fail_cnt++;
      $display("lsu_ready_o never fell during back-to-back issue");
    end
    // Flush with one committed store and two speculative ones
    commit_allow = 1;
    issue(lsu_pkg::SW, 32'h300, 12'h000, 32'hCAFE0001);
    issue(lsu_pkg::SW, 32'h300, 12'h004, 32'hCAFE0002);
    issue(lsu_pkg::SH, 32'h300, 12'h008, 32'hBEEF);
    t = 0;
    while ((exp_st_valid || commit_allow != 0) && t < 200) begin
      @(negedge clk_i);
      t++;
    end
    if (t == 200) report_timeout("flush setup stores did not settle");
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    wait_drain();
    for (int i = 0; i < 256; i++) begin
      assert (i_mem.mem[i] == image[i]) else begin
        mism_cnt++;
        $display("mismatch mem[%h]: expected %h, got %h", i[7:0], image[i], i_mem.mem[i]);
      end
    end
    // Faulting accesses never reach a port, committed stores write once
    assert (ld_grants == ld_reads) else begin
      mism_cnt++;
      $display("mismatch ld_mem_req_o grants: expected %h, got %h", ld_reads, ld_grants);
    end
    assert (st_grants == commit_idx) else begin
      mism_cnt++;
      $display("mismatch st_mem_req_o grants: expected %h, got %h", commit_idx, st_grants);
    end
    $display("mismatches: %0d, other errors: %0d", mism_cnt, fail_cnt);
    if (mism_cnt == 0 && fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- lsu.f
hw/lsu_pkg.sv
hw/lsu_agu.sv
hw/lsu_issue_queue.sv
hw/lsu_load_unit.sv
hw/lsu_store_queue.sv
hw/lsu_result_pipe.sv
hw/lsu_top.sv
tb/lsu_tb_mem.sv
tb/lsu_tb.sv

//--- Makefile
TOP := lsu_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f lsu.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
